//--- source/trace_settings.svh
// tracer settings: data width, depth counter widths, stack and link register numbers

`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

// --------------------------------------------------
// datapath
// --------------------------------------------------

// data and address width
`define TRACE_XLEN 32

// --------------------------------------------------
// depth counters
// --------------------------------------------------

// trap nesting, small range is enough
`define TRACE_TRAP_DEPTH_W 4
`define TRACE_STACK_DEPTH_W 32

// abi register numbers
`define TRACE_SP_REG 2
`define TRACE_LINK_REG 1

`endif

//--- source/rv_isa_pkg.sv
// rv32i encoding types: major opcodes, instruction classes, decoded instruction bundle

`default_nettype none

`include "trace_settings.svh"

package rv_isa_pkg;

    // --------------------------------------------------
    // major opcodes, bits [6:0] of a 32-bit encoding
    // --------------------------------------------------
    typedef enum logic [6:0] {
        op_lui     = 7'b0110111,
        op_auipc   = 7'b0010111,
        op_jal     = 7'b1101111,
        op_jalr    = 7'b1100111,
        op_branch  = 7'b1100011,
        op_load    = 7'b0000011,
        op_store   = 7'b0100011,
        op_opimm   = 7'b0010011,
        op_op      = 7'b0110011,
        op_miscmem = 7'b0001111,
        op_system  = 7'b1110011
    } opcode_e;

    // instruction class as reported in a trace record
    typedef enum logic [3:0] {
        cls_lui,
        cls_auipc,
        cls_jal,
        cls_jalr,
        cls_branch,
        cls_load,
        cls_store,
        cls_opimm,
        cls_op,
        cls_miscmem,
        cls_system,
        cls_unknown
    } ins_class_e;

    typedef logic [4:0] reg_addr_t;

    // --------------------------------------------------
    // decoded instruction
    // --------------------------------------------------
    typedef struct packed {
        ins_class_e            ins_class;
        reg_addr_t             rd;
        reg_addr_t             rs1;
        reg_addr_t             rs2;
        logic [`TRACE_XLEN-1:0] imm;       // sign extended per format
        logic                  is_call;
        logic                  is_rtn;
        logic                  is_stack_adj;
        logic                  is_trap_rtn;
    } ins_info_t;

endpackage

`default_nettype wire

//--- source/trace_pkg.sv
// tracer interface types: execute and trap bundles, depths, cause categories, trace record

`default_nettype none

`include "trace_settings.svh"

package trace_pkg;

    // --------------------------------------------------
    // inputs from the core
    // --------------------------------------------------
    typedef struct packed {
        logic [`TRACE_XLEN-1:0] pc;
        logic [`TRACE_XLEN-1:0] ins;
        logic [`TRACE_XLEN-1:0] rs2_data;
        logic [`TRACE_XLEN-1:0] alu_dout;
        logic [1:0]             mode;
    } exec_info_t;

    typedef struct packed {
        logic                   jump;
        logic [`TRACE_XLEN-1:0] cause;
        logic [`TRACE_XLEN-1:0] entry_addr;
        logic [`TRACE_XLEN-1:0] rtn_addr;
    } trap_info_t;

    // depth counts, both signed
    typedef logic signed [`TRACE_TRAP_DEPTH_W-1:0]  trap_depth_t;
    typedef logic signed [`TRACE_STACK_DEPTH_W-1:0] stack_depth_t;

    // trap cause reduced to a category, privilege level dropped
    typedef enum logic [3:0] {
        cat_none,
        cat_sw_int,
        cat_timer_int,
        cat_ext_int,
        cat_ins_misaligned,
        cat_ins_fault,
        cat_illegal,
        cat_load_misaligned,
        cat_load_fault,
        cat_store_misaligned,
        cat_store_fault,
        cat_ecall,
        cat_other
    } cause_cat_e;

    typedef enum logic {
        ev_commit,
        ev_trap
    } event_kind_e;

    // --------------------------------------------------
    // output record
    // --------------------------------------------------
    typedef struct packed {
        event_kind_e             kind;
        logic [1:0]              mode;
        logic [`TRACE_XLEN-1:0]  pc;
        logic [`TRACE_XLEN-1:0]  ins;
        rv_isa_pkg::ins_class_e  ins_class;
        logic                    is_call;
        logic                    is_rtn;
        cause_cat_e              cause_cat;
        logic [`TRACE_XLEN-1:0]  target;
        trap_depth_t             trap_depth;
        stack_depth_t            stack_depth;
    } trace_record_t;

endpackage

`default_nettype wire

//--- source/ins_classifier.sv
// combinational rv32i decode: class, register fields, immediate, call/return/stack/xret flags

`timescale 1ns/10ps
`default_nettype none

`include "trace_settings.svh"

module ins_classifier (
    input  wire logic [31:0]          ins_i,
    output rv_isa_pkg::ins_info_t     info_o
);

    localparam int XLEN = `TRACE_XLEN;

    logic [2:0]              funct3;
    logic [11:0]             funct12;
    rv_isa_pkg::reg_addr_t   rd;
    rv_isa_pkg::reg_addr_t   rs1;
    rv_isa_pkg::reg_addr_t   rs2;
    logic [XLEN-1:0]         imm_i;
    logic [XLEN-1:0]         imm_s;
    logic [XLEN-1:0]         imm_b;
    logic [XLEN-1:0]         imm_u;
    logic [XLEN-1:0]         imm_j;
    rv_isa_pkg::ins_class_e  ins_class;
    logic [XLEN-1:0]         imm;

    // --------------------------------------------------
    // raw fields
    // --------------------------------------------------
    assign funct3  = ins_i[14:12];
    assign funct12 = ins_i[31:20];
    assign rd      = ins_i[11:7];
    assign rs1     = ins_i[19:15];
    assign rs2     = ins_i[24:20];

    // immediates for each format
    assign imm_i = {{(XLEN-12){ins_i[31]}}, ins_i[31:20]};
    assign imm_s = {{(XLEN-12){ins_i[31]}}, ins_i[31:25], ins_i[11:7]};
    assign imm_b = {{(XLEN-12){ins_i[31]}}, ins_i[7], ins_i[30:25], ins_i[11:8], 1'b0};
    assign imm_u = {{(XLEN-32){ins_i[31]}}, ins_i[31:12], 12'b0};
    assign imm_j = {{(XLEN-20){ins_i[31]}}, ins_i[19:12], ins_i[20], ins_i[30:21], 1'b0};

    // --------------------------------------------------
    // class and format select
    // --------------------------------------------------
    always_comb begin
        ins_class = rv_isa_pkg::cls_unknown;
        imm       = '0;
        case (rv_isa_pkg::opcode_e'(ins_i[6:0]))
            rv_isa_pkg::op_lui: begin
                ins_class = rv_isa_pkg::cls_lui;
                imm       = imm_u;
            end
            rv_isa_pkg::op_auipc: begin
                ins_class = rv_isa_pkg::cls_auipc;
                imm       = imm_u;
            end
            rv_isa_pkg::op_jal: begin
                ins_class = rv_isa_pkg::cls_jal;
                imm       = imm_j;
            end
            rv_isa_pkg::op_jalr: begin
                ins_class = rv_isa_pkg::cls_jalr;
                imm       = imm_i;
            end
            rv_isa_pkg::op_branch: begin
                ins_class = rv_isa_pkg::cls_branch;
                imm       = imm_b;
            end
            rv_isa_pkg::op_load: begin
                ins_class = rv_isa_pkg::cls_load;
                imm       = imm_i;
            end
            rv_isa_pkg::op_store: begin
                ins_class = rv_isa_pkg::cls_store;
                imm       = imm_s;
            end
            rv_isa_pkg::op_opimm: begin
                ins_class = rv_isa_pkg::cls_opimm;
                imm       = imm_i;
            end
            rv_isa_pkg::op_op: begin
                ins_class = rv_isa_pkg::cls_op;
            end
            rv_isa_pkg::op_miscmem: begin
                ins_class = rv_isa_pkg::cls_miscmem;
                imm       = imm_i;
            end
            rv_isa_pkg::op_system: begin
                // csr forms carry the csr number here
                ins_class = rv_isa_pkg::cls_system;
                imm       = imm_i;
            end
            default: begin
                ins_class = rv_isa_pkg::cls_unknown;
            end
        endcase
    end

    // --------------------------------------------------
    // output bundle and flags
    // --------------------------------------------------
    always_comb begin
        info_o           = '0;
        info_o.ins_class = ins_class;
        info_o.rd        = rd;
        info_o.rs1       = rs1;
        info_o.rs2       = rs2;
        info_o.imm       = imm;

        // jal with the link register as destination
        info_o.is_call = (ins_class == rv_isa_pkg::cls_jal) &&
                         (rd == rv_isa_pkg::reg_addr_t'(`TRACE_LINK_REG));

        // jalr through the link register, no offset
        info_o.is_rtn = (ins_class == rv_isa_pkg::cls_jalr) &&
                        (rs1 == rv_isa_pkg::reg_addr_t'(`TRACE_LINK_REG)) &&
                        (imm == '0);

        // addi sp, sp, imm
        info_o.is_stack_adj = (ins_class == rv_isa_pkg::cls_opimm) && (funct3 == 3'b000) &&
                              (rd == rv_isa_pkg::reg_addr_t'(`TRACE_SP_REG)) &&
                              (rs1 == rv_isa_pkg::reg_addr_t'(`TRACE_SP_REG));

        // uret, sret, mret
        info_o.is_trap_rtn = (ins_class == rv_isa_pkg::cls_system) && (funct3 == 3'b000) &&
                             (rd == '0) && (rs1 == '0) &&
                             ((funct12 == 12'h002) || (funct12 == 12'h102) ||
                              (funct12 == 12'h302));
    end

endmodule

`default_nettype wire

//--- source/depth_counter.sv
// signed depth accumulator with synchronous reset and adjust strobe

`timescale 1ns/10ps
`default_nettype none

module depth_counter #(
    parameter type count_t = logic signed [7:0]
) (
    input  wire logic   clk_i,
    input  wire logic   reset_i,
    input  wire logic   adjust_i,
    input  wire count_t delta_i,
    output count_t      count_o
);

    count_t count_q;

    // --------------------------------------------------
    // accumulate on strobe
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (adjust_i) begin
            // negative deltas wrap at the count_t width
            count_q <= count_q + delta_i;
        end
    end

    assign count_o = count_q;

endmodule

`default_nettype wire

//--- source/trace_record_builder.sv
// event selection, trap cause categories, depth adjust requests and registered trace record

`timescale 1ns/10ps
`default_nettype none

`include "trace_settings.svh"

module trace_record_builder (
    input  wire logic                      clk_i,
    input  wire logic                      reset_i,
    input  wire logic                      ex_stage_en_i,
    input  wire logic                      execute_commit_i,
    input  wire trace_pkg::exec_info_t     exec_i,
    input  wire trace_pkg::trap_info_t     trap_i,
    input  wire rv_isa_pkg::ins_info_t     info_i,
    input  wire trace_pkg::trap_depth_t    trap_depth_i,
    input  wire trace_pkg::stack_depth_t   stack_depth_i,
    output logic                           trap_adjust_o,
    output trace_pkg::trap_depth_t         trap_delta_o,
    output logic                           stack_adjust_o,
    output trace_pkg::stack_depth_t        stack_delta_o,
    output logic                           trace_valid_o,
    output trace_pkg::trace_record_t       trace_o
);

    logic                      trap_event;
    logic                      commit_event;
    logic                      trap_rtn_event;
    trace_pkg::trace_record_t  record_d;

    // --------------------------------------------------
    // cause reduction
    // --------------------------------------------------
    function automatic trace_pkg::cause_cat_e cause_category(
        input logic [`TRACE_XLEN-1:0] cause
    );
        trace_pkg::cause_cat_e cat;
        cat = trace_pkg::cat_other;
        // only the low four code bits are defined
        if (cause[`TRACE_XLEN-2:4] == '0) begin
            if (cause[`TRACE_XLEN-1]) begin
                case (cause[3:0])
                    4'd0, 4'd1, 4'd3:  cat = trace_pkg::cat_sw_int;
                    4'd4, 4'd5, 4'd7:  cat = trace_pkg::cat_timer_int;
                    4'd8, 4'd9, 4'd11: cat = trace_pkg::cat_ext_int;
                    default:           cat = trace_pkg::cat_other;
                endcase
            end else begin
                case (cause[3:0])
                    4'd0:              cat = trace_pkg::cat_ins_misaligned;
                    4'd1:              cat = trace_pkg::cat_ins_fault;
                    4'd2:              cat = trace_pkg::cat_illegal;
                    4'd4:              cat = trace_pkg::cat_load_misaligned;
                    4'd5:              cat = trace_pkg::cat_load_fault;
                    4'd6:              cat = trace_pkg::cat_store_misaligned;
                    4'd7:              cat = trace_pkg::cat_store_fault;
                    4'd8, 4'd9, 4'd11: cat = trace_pkg::cat_ecall;
                    default:           cat = trace_pkg::cat_other;   // breakpoint and beyond
                endcase
            end
        end
        return cat;
    endfunction

    // --------------------------------------------------
    // event rule with trap entry winning over commit
    // --------------------------------------------------
    assign trap_event     = ex_stage_en_i & trap_i.jump;
    assign commit_event   = ex_stage_en_i & ~trap_i.jump & execute_commit_i;
    assign trap_rtn_event = commit_event & info_i.is_trap_rtn;

    // depth update requests
    assign trap_adjust_o  = trap_event | trap_rtn_event;
    assign trap_delta_o   = trap_event ? trace_pkg::trap_depth_t'(1)
                                       : trace_pkg::trap_depth_t'(-1);
    assign stack_adjust_o = commit_event & info_i.is_stack_adj;
    assign stack_delta_o  = trace_pkg::stack_depth_t'($signed(info_i.imm));

    // --------------------------------------------------
    // next record
    // --------------------------------------------------
    always_comb begin
        record_d           = '0;
        record_d.kind      = trap_event ? trace_pkg::ev_trap : trace_pkg::ev_commit;
        record_d.mode      = exec_i.mode;
        record_d.pc        = exec_i.pc;
        record_d.ins       = exec_i.ins;
        record_d.ins_class = info_i.ins_class;
        // call and return only mean something when the instruction retires
        record_d.is_call   = commit_event & info_i.is_call;
        record_d.is_rtn    = commit_event & info_i.is_rtn;
        record_d.cause_cat = trap_event ? cause_category(trap_i.cause) : trace_pkg::cat_none;

        if (trap_event) begin
            record_d.target = trap_i.entry_addr;
        end else if (trap_rtn_event) begin
            record_d.target = trap_i.rtn_addr;
        end else begin
            record_d.target = exec_i.alu_dout;
        end

        // xret reports the depth it returns to
        record_d.trap_depth  = trap_rtn_event ? trap_depth_i - trace_pkg::trap_depth_t'(1)
                                              : trap_depth_i;
        record_d.stack_depth = stack_depth_i;
    end

    // --------------------------------------------------
    // output registers
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            trace_valid_o <= 1'b0;
        end else begin
            trace_valid_o <= trap_event | commit_event;
        end
    end

    always_ff @(posedge clk_i) begin
        if (trap_event | commit_event) begin
            trace_o <= record_d;
        end
    end

endmodule

`default_nettype wire

//--- source/core_tracer.sv
// core tracer top level with instruction classifier, trap and stack depth counters and record builder

`timescale 1ns/10ps
`default_nettype none

module core_tracer (
    input  wire logic                  clk_i,
    input  wire logic                  reset_i,
    input  wire logic                  ex_stage_en_i,
    input  wire logic                  execute_commit_i,
    input  wire trace_pkg::exec_info_t exec_i,
    input  wire trace_pkg::trap_info_t trap_i,
    output logic                       trace_valid_o,
    output trace_pkg::trace_record_t   trace_o
);

    rv_isa_pkg::ins_info_t    ins_info;
    logic                     trap_adjust;
    trace_pkg::trap_depth_t   trap_delta;
    trace_pkg::trap_depth_t   trap_depth;
    logic                     stack_adjust;
    trace_pkg::stack_depth_t  stack_delta;
    trace_pkg::stack_depth_t  stack_depth;

    // --------------------------------------------------
    // decode
    // --------------------------------------------------
    ins_classifier ins_classifier_i (
        .ins_i  (exec_i.ins),
        .info_o (ins_info)
    );

    // --------------------------------------------------
    // depth tracking
    // --------------------------------------------------
    depth_counter #(
        .count_t (trace_pkg::trap_depth_t)
    ) trap_depth_counter_i (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .adjust_i (trap_adjust),
        .delta_i  (trap_delta),
        .count_o  (trap_depth)
    );

    depth_counter #(
        .count_t (trace_pkg::stack_depth_t)
    ) stack_depth_counter_i (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .adjust_i (stack_adjust),
        .delta_i  (stack_delta),
        .count_o  (stack_depth)
    );

    // record assembly one cycle after the sampling edge
    trace_record_builder trace_record_builder_i (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .ex_stage_en_i    (ex_stage_en_i),
        .execute_commit_i (execute_commit_i),
        .exec_i           (exec_i),
        .trap_i           (trap_i),
        .info_i           (ins_info),
        .trap_depth_i     (trap_depth),
        .stack_depth_i    (stack_depth),
        .trap_adjust_o    (trap_adjust),
        .trap_delta_o     (trap_delta),
        .stack_adjust_o   (stack_adjust),
        .stack_delta_o    (stack_delta),
        .trace_valid_o    (trace_valid_o),
        .trace_o          (trace_o)
    );

endmodule

`default_nettype wire

//--- sim/core_tracer_tb.sv
// core tracer testbench with clock, reset, stimulus tasks, reference model and record assertions

`timescale 1ns/10ps
`default_nettype none

`include "trace_settings.svh"

module core_tracer_tb;

    localparam int RESET_CYCLES = 5;
    localparam int N_RANDOM     = 48;
    localparam int N_STACK      = 40;
    localparam int N_CAUSES     = 13;
    // about 30 more cycles of fixed tests plus margin
    localparam int CYCLE_LIMIT  = RESET_CYCLES + N_RANDOM + N_STACK + 2 * N_CAUSES + 60;

    localparam logic [4:0]  SP_REG   = 5'(`TRACE_SP_REG);
    localparam logic [4:0]  LINK_REG = 5'(`TRACE_LINK_REG);
    localparam logic [31:0] INS_URET = 32'h00200073;
    localparam logic [31:0] INS_SRET = 32'h10200073;
    localparam logic [31:0] INS_MRET = 32'h30200073;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     ex_stage_en;
    logic                     execute_commit;
    trace_pkg::exec_info_t    exec_in;
    trace_pkg::trap_info_t    trap_in;
    logic                     trace_valid;
    trace_pkg::trace_record_t trace;

    // reference model state
    logic                     exp_valid;
    trace_pkg::trace_record_t exp_rec;
    trace_pkg::trap_depth_t   model_trap_depth;
    trace_pkg::stack_depth_t  model_stack_depth;

    integer seed;
    int     cycle_count   = 0;
    int     error_count   = 0;
    int     errors_before = 0;
    int     test_count    = 0;
    int     event_count   = 0;

    // every major opcode and one that decodes to nothing
    logic [6:0]  opcode_table [12] = '{7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111,
                                       7'b1100011, 7'b0000011, 7'b0100011, 7'b0010011,
                                       7'b0110011, 7'b0001111, 7'b1110011, 7'b1111111};
    logic [31:0] cause_table [N_CAUSES] = '{32'h80000003, 32'h80000007, 32'h8000000b,
                                            32'h0, 32'h1, 32'h2, 32'h4, 32'h5, 32'h6,
                                            32'h7, 32'hb, 32'h3, 32'h10};

    core_tracer core_tracer_i (
        .clk_i            (clk),
        .reset_i          (reset),
        .ex_stage_en_i    (ex_stage_en),
        .execute_commit_i (execute_commit),
        .exec_i           (exec_in),
        .trap_i           (trap_in),
        .trace_valid_o    (trace_valid),
        .trace_o          (trace)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic rv_isa_pkg::ins_class_e expected_class(input logic [6:0] opcode);
        case (opcode)
            7'b0110111: return rv_isa_pkg::cls_lui;
            7'b0010111: return rv_isa_pkg::cls_auipc;
            7'b1101111: return rv_isa_pkg::cls_jal;
            7'b1100111: return rv_isa_pkg::cls_jalr;
            7'b1100011: return rv_isa_pkg::cls_branch;
            7'b0000011: return rv_isa_pkg::cls_load;
            7'b0100011: return rv_isa_pkg::cls_store;
            7'b0010011: return rv_isa_pkg::cls_opimm;
            7'b0110011: return rv_isa_pkg::cls_op;
            7'b0001111: return rv_isa_pkg::cls_miscmem;
            7'b1110011: return rv_isa_pkg::cls_system;
            default:    return rv_isa_pkg::cls_unknown;
        endcase
    endfunction

    // categories follow the mcause interrupt flag and low code bits
    function automatic trace_pkg::cause_cat_e expected_cause(input logic [31:0] cause);
        if (cause[30:4] != '0) begin
            return trace_pkg::cat_other;
        end
        case ({cause[31], cause[3:0]})
            5'h10, 5'h11, 5'h13: return trace_pkg::cat_sw_int;
            5'h14, 5'h15, 5'h17: return trace_pkg::cat_timer_int;
            5'h18, 5'h19, 5'h1b: return trace_pkg::cat_ext_int;
            5'h00:               return trace_pkg::cat_ins_misaligned;
            5'h01:               return trace_pkg::cat_ins_fault;
            5'h02:               return trace_pkg::cat_illegal;
            5'h04:               return trace_pkg::cat_load_misaligned;
            5'h05:               return trace_pkg::cat_load_fault;
            5'h06:               return trace_pkg::cat_store_misaligned;
            5'h07:               return trace_pkg::cat_store_fault;
            5'h08, 5'h09, 5'h0b: return trace_pkg::cat_ecall;
            default:             return trace_pkg::cat_other;
        endcase
    endfunction

    always @(posedge clk) begin : reference_model
        logic [31:0]              ins;
        logic                     trap_ev;
        logic                     commit_ev;
        logic                     xret;
        trace_pkg::trace_record_t rec;
        ins       = exec_in.ins;
        trap_ev   = ex_stage_en && trap_in.jump;
        commit_ev = ex_stage_en && !trap_in.jump && execute_commit;
        xret      = commit_ev && (ins == INS_URET || ins == INS_SRET || ins == INS_MRET);
        rec           = '0;
        rec.kind      = trap_ev ? trace_pkg::ev_trap : trace_pkg::ev_commit;
        rec.mode      = exec_in.mode;
        rec.pc        = exec_in.pc;
        rec.ins       = ins;
        rec.ins_class = expected_class(ins[6:0]);
        rec.is_call   = commit_ev && ins[6:0] == 7'b1101111 && ins[11:7] == LINK_REG;
        rec.is_rtn    = commit_ev && ins[6:0] == 7'b1100111 && ins[19:15] == LINK_REG &&
                        ins[31:20] == 12'd0;
        rec.cause_cat = trap_ev ? expected_cause(trap_in.cause) : trace_pkg::cat_none;
        rec.target    = trap_ev ? trap_in.entry_addr : (xret ? trap_in.rtn_addr : exec_in.alu_dout);
        rec.trap_depth  = xret ? model_trap_depth - trace_pkg::trap_depth_t'(1) : model_trap_depth;
        rec.stack_depth = model_stack_depth;
        if (reset) begin
            exp_valid         <= 1'b0;
            model_trap_depth  <= '0;
            model_stack_depth <= '0;
        end else begin
            exp_valid <= trap_ev || commit_ev;
            if (trap_ev || commit_ev) begin
                exp_rec     <= rec;
                event_count <= event_count + 1;
            end
            if (trap_ev) begin
                model_trap_depth <= model_trap_depth + trace_pkg::trap_depth_t'(1);
            end else if (xret) begin
                model_trap_depth <= model_trap_depth - trace_pkg::trap_depth_t'(1);
            end
            // addi sp, sp, imm
            if (commit_ev && ins[6:0] == 7'b0010011 && ins[14:12] == 3'd0 &&
                ins[11:7] == SP_REG && ins[19:15] == SP_REG) begin
                model_stack_depth <= model_stack_depth +
                                     {{(`TRACE_STACK_DEPTH_W-12){ins[31]}}, ins[31:20]};
            end
        end
    end

    // --------------------------------------------------
    // record checks at the falling edge where outputs are stable
    // --------------------------------------------------
    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
        error_count++;
    endtask

    check_valid: assert property (@(negedge clk) trace_valid == exp_valid)
        else report_mismatch("trace_valid_o", 32'(exp_valid), 32'(trace_valid));
    check_kind: assert property (@(negedge clk) exp_valid |-> trace.kind == exp_rec.kind)
        else report_mismatch("trace_o.kind", 32'(exp_rec.kind), 32'(trace.kind));
    check_mode: assert property (@(negedge clk) exp_valid |-> trace.mode == exp_rec.mode)
        else report_mismatch("trace_o.mode", 32'(exp_rec.mode), 32'(trace.mode));
    check_pc: assert property (@(negedge clk) exp_valid |-> trace.pc == exp_rec.pc)
        else report_mismatch("trace_o.pc", exp_rec.pc, trace.pc);
    check_ins: assert property (@(negedge clk) exp_valid |-> trace.ins == exp_rec.ins)
        else report_mismatch("trace_o.ins", exp_rec.ins, trace.ins);
    check_class: assert property (@(negedge clk)
                                  exp_valid |-> trace.ins_class == exp_rec.ins_class)
        else report_mismatch("trace_o.ins_class", 32'(exp_rec.ins_class), 32'(trace.ins_class));
    check_call: assert property (@(negedge clk) exp_valid |-> trace.is_call == exp_rec.is_call)
        else report_mismatch("trace_o.is_call", 32'(exp_rec.is_call), 32'(trace.is_call));
    check_rtn: assert property (@(negedge clk) exp_valid |-> trace.is_rtn == exp_rec.is_rtn)
        else report_mismatch("trace_o.is_rtn", 32'(exp_rec.is_rtn), 32'(trace.is_rtn));
    check_cause: assert property (@(negedge clk)
                                  exp_valid |-> trace.cause_cat == exp_rec.cause_cat)
        else report_mismatch("trace_o.cause_cat", 32'(exp_rec.cause_cat), 32'(trace.cause_cat));
    check_target: assert property (@(negedge clk) exp_valid |-> trace.target == exp_rec.target)
        else report_mismatch("trace_o.target", exp_rec.target, trace.target);
    check_trap_depth: assert property (@(negedge clk)
                                       exp_valid |-> trace.trap_depth == exp_rec.trap_depth)
        else report_mismatch("trace_o.trap_depth", 32'(exp_rec.trap_depth),
                             32'(trace.trap_depth));
    check_stack_depth: assert property (@(negedge clk)
                                        exp_valid |-> trace.stack_depth == exp_rec.stack_depth)
        else report_mismatch("trace_o.stack_depth", exp_rec.stack_depth, trace.stack_depth);

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    task automatic drive_event(input logic en, input logic commit, input logic jump,
                               input logic [31:0] ins, input logic [31:0] cause);
        @(negedge clk);
        ex_stage_en        = en;
        execute_commit     = commit;
        exec_in.pc         = $random(seed);
        exec_in.pc[1:0]    = 2'b00;
        exec_in.ins        = ins;
        exec_in.rs2_data   = $random(seed);
        exec_in.alu_dout   = $random(seed);
        exec_in.mode       = 2'($random(seed));
        trap_in.jump       = jump;
        trap_in.cause      = cause;
        trap_in.entry_addr = $random(seed);
        trap_in.rtn_addr   = $random(seed);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            execute_commit = 1'b0;
            trap_in.jump   = 1'b0;
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %s finished with %0d errors", test_count, name,
                 error_count - errors_before);
        errors_before = error_count;
    endtask

    initial begin : stimulus
        logic [31:0] ins;
        logic [1:0]  sel;
        seed           = 32'h8be1;
        reset          = 1'b1;
        ex_stage_en    = 1'b0;
        execute_commit = 1'b0;
        exec_in        = '0;
        trap_in        = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        idle(3);
        end_test("reset and idle");

        for (int i = 0; i < N_RANDOM; i++) begin
            ins      = $random(seed);
            ins[6:0] = opcode_table[i % 12];
            drive_event(1'b1, 1'b1, 1'b0, ins, 32'd0);
        end
        idle(2);
        end_test("random opcodes back to back");

        ins = $random(seed);
        drive_event(1'b1, 1'b1, 1'b0, {ins[31:12], 5'd1, 7'b1101111}, 32'd0);
        drive_event(1'b1, 1'b1, 1'b0, {ins[31:12], 5'd5, 7'b1101111}, 32'd0);
        drive_event(1'b1, 1'b1, 1'b0, {12'd0, 5'd1, 3'd0, 5'd0, 7'b1100111}, 32'd0);
        drive_event(1'b1, 1'b1, 1'b0, {12'd8, 5'd1, 3'd0, 5'd0, 7'b1100111}, 32'd0);
        drive_event(1'b1, 1'b1, 1'b0, {12'd0, 5'd6, 3'd0, 5'd0, 7'b1100111}, 32'd0);
        idle(2);
        end_test("calls and returns");

        for (int i = 0; i < N_STACK; i++) begin
            ins = $random(seed);
            sel = 2'($random(seed));
            case (sel)
                2'd0, 2'd1: ins = {ins[31:20], 5'd2, 3'd0, 5'd2, 7'b0010011};
                2'd2:       ins = {ins[31:20], 5'd5, 3'd0, 5'd2, 7'b0010011};
                default:    ins[6:0] = 7'b0110011;
            endcase
            drive_event(1'b1, 1'b1, 1'b0, ins, 32'd0);
        end
        idle(2);
        end_test("stack depth");

        // odd entries also raise commit and are followed by an mret
        for (int i = 0; i < N_CAUSES; i++) begin
            drive_event(1'b1, 1'(i % 2), 1'b1, $random(seed), cause_table[i]);
            if (i % 2 == 1) begin
                drive_event(1'b1, 1'b1, 1'b0, INS_MRET, 32'd0);
            end
        end
        drive_event(1'b1, 1'b1, 1'b0, INS_SRET, 32'd0);
        drive_event(1'b1, 1'b1, 1'b0, INS_URET, 32'd0);
        drive_event(1'b1, 1'b1, 1'b0, INS_MRET, 32'd0);
        idle(2);
        end_test("traps and returns");

        drive_event(1'b0, 1'b1, 1'b0, {12'd16, 5'd2, 3'd0, 5'd2, 7'b0010011}, 32'd0);
        drive_event(1'b0, 1'b0, 1'b1, $random(seed), 32'h2);
        drive_event(1'b1, 1'b1, 1'b0, 32'h00000013, 32'd0);
        drive_event(1'b0, 1'b1, 1'b0, INS_MRET, 32'd0);
        drive_event(1'b1, 1'b1, 1'b0, 32'h00000013, 32'd0);
        idle(2);
        end_test("execute stage disabled");

        $display("summary: %0d tests, %0d events, %0d errors", test_count, event_count,
                 error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+source
source/rv_isa_pkg.sv
source/trace_pkg.sv
source/ins_classifier.sv
source/depth_counter.sv
source/trace_record_builder.sv
source/core_tracer.sv
sim/core_tracer_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the core tracer testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module core_tracer_tb \
    -o core_tracer_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/core_tracer_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
